/* design/adc_pkg.sv */
/*
  shared definitions for the multislope adc controller
  - count, integration and spi frame widths
  - reference switch codes, sequencer states, register map
  - settings, result and event structs
*/

package adc_pkg;

  localparam int cnt_w   = 24;
  localparam int int_w   = 32;
  localparam int frame_w = 32;

  // {ref_n, ref_p} switch pair
  typedef enum logic [1:0] {
    ref_none     = 2'b00,
    ref_pos      = 2'b01,
    ref_neg      = 2'b10,
    ref_slow_pos = 2'b11
  } ref_code_t;

  typedef enum logic [2:0] {
    st_init,
    st_fix_pos,
    st_var,
    st_fix_neg,
    st_var2,
    st_rundown,
    st_done
  } seq_state_t;

  // low 7 bits of the spi address byte
  typedef enum logic [6:0] {
    a_count_up   = 7'd9,
    a_count_down = 7'd10,
    a_rundown    = 7'd11,
    a_trans_up   = 7'd12,
    a_trans_down = 7'd14,
    a_test       = 7'd15,
    a_init_n     = 7'd18,
    a_fix_n      = 7'd20,
    a_var_n      = 7'd21,
    a_int_lo     = 7'd22,
    a_int_hi     = 7'd23,
    a_slow       = 7'd24,
    a_himux      = 7'd25,
    a_fix_up     = 7'd26,
    a_fix_down   = 7'd27
  } reg_addr_t;

  localparam logic [cnt_w-1:0] test_word = 24'hffffff;

  typedef struct packed {
    logic [cnt_w-1:0] init_n;
    logic [cnt_w-1:0] fix_n;
    logic [cnt_w-1:0] var_n;
    logic [int_w-1:0] int_n;
    logic             slow_rundown;
    logic [3:0]       himux_sel;
  } mod_cfg_t;

  typedef struct packed {
    logic [cnt_w-1:0] count_up;
    logic [cnt_w-1:0] count_down;
    logic [cnt_w-1:0] trans_up;
    logic [cnt_w-1:0] trans_down;
    logic [cnt_w-1:0] fix_up;
    logic [cnt_w-1:0] fix_down;
    logic [cnt_w-1:0] rundown;
  } mod_result_t;

  // one-cycle strobes, sequencer to counters
  typedef struct packed {
    logic clear;
    logic fix_pos;
    logic fix_neg;
    logic var_up;
    logic var_down;
    logic trans_up;
    logic trans_down;
    logic finish;
  } slope_ev_t;

endpackage

/* design/spi_target.sv */
/*
  spi target, sampled in the system clock domain
  - two-flop synchronisers on sck, cs_n and mosi
  - 32-bit frame shift in, 24-bit read word shift out
  - frame strobe when cs_n rises after a full frame
*/

`timescale 1ns/100ps

module spi_target #(
  parameter int frame_w = 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sck,
  input  logic                      cs_n,
  input  logic                      mosi,
  input  logic [adc_pkg::cnt_w-1:0] rd_word,
  output logic                      miso,
  output logic                      frame_stb,
  output logic [frame_w-1:0]        frame
);

  import adc_pkg::*;

  localparam int addr_w = frame_w - cnt_w;
  localparam int bc_w   = $clog2(frame_w + 1);

  logic [2:0]       sck_q;
  logic [2:0]       cs_q;
  logic [1:0]       mosi_q;
  logic             sck_rise;
  logic             sck_fall;
  logic             cs_s;
  logic             cs_rise;
  logic [bc_w-1:0]  bit_cnt;
  logic             load_pend;
  logic [cnt_w-1:0] out_sr;

  ////////////////////
  // pin synchronisers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_q  <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
    end
    else
    begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  // third flop only for edge detect
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_s     = cs_q[1];
  assign cs_rise  = cs_q[1] & ~cs_q[2];

  ////////////////////
  // bit count, miso, frame strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      load_pend <= 1'b0;
      miso      <= 1'b0;
      frame_stb <= 1'b0;
    end
    else
    begin
      // only an exact frame counts
      frame_stb <= cs_rise && (bit_cnt == bc_w'(frame_w));
      if (cs_s)
      begin
        bit_cnt   <= '0;
        load_pend <= 1'b0;
        miso      <= 1'b0;
      end
      else
      begin
        // address byte complete after this rise
        load_pend <= sck_rise && (bit_cnt == bc_w'(addr_w - 1));
        if (sck_rise && (bit_cnt != '1))
          bit_cnt <= bit_cnt + 1'b1;
        // data bits leave after the falling edge
        if (sck_fall && (bit_cnt >= bc_w'(addr_w)))
          miso <= out_sr[cnt_w-1];
      end
    end
  end

  // fill msb first, address lands in the top byte
  always_ff @(posedge clk)
  begin
    if (!cs_s && sck_rise && (bit_cnt < bc_w'(frame_w)))
      frame[frame_w - 1 - bit_cnt] <= mosi_q[1];
    if (load_pend)
      out_sr <= rd_word;
    else if (!cs_s && sck_fall && (bit_cnt >= bc_w'(addr_w)))
      out_sr <= {out_sr[cnt_w-2:0], 1'b0};
  end

  // host keeps sck idle outside a frame
  a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs_s |-> !(sck_rise || sck_fall));

endmodule

/* design/reg_bank.sv */
/*
  register bank behind the spi target
  - modulation settings with reset defaults
  - write decode on the frame strobe
  - read word select for the addressed register
*/

`timescale 1ns/100ps

module reg_bank #(
  parameter logic [adc_pkg::cnt_w-1:0] def_init_n = 24'd10000,
  parameter logic [adc_pkg::cnt_w-1:0] def_fix_n  = 24'd700,
  parameter logic [adc_pkg::cnt_w-1:0] def_var_n  = 24'd5500,
  parameter logic [adc_pkg::int_w-1:0] def_int_n  = 32'd4000000,
  parameter logic                      def_slow   = 1'b1,
  parameter logic [3:0]                def_himux  = 4'b1011
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        frame_stb,
  input  logic [adc_pkg::frame_w-1:0] frame,
  input  adc_pkg::mod_result_t        result,
  output adc_pkg::mod_cfg_t           cfg,
  output logic [adc_pkg::cnt_w-1:0]   rd_word
);

  import adc_pkg::*;

  reg_addr_t        addr;
  logic [cnt_w-1:0] wr_val;
  logic             wr_en;

  // top byte is the address, bit 7 marks read only
  assign addr   = reg_addr_t'(frame[frame_w-2:cnt_w]);
  assign wr_val = frame[cnt_w-1:0];
  assign wr_en  = frame_stb & ~frame[frame_w-1];

  ////////////////////
  // settings
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg.init_n       <= def_init_n;
      cfg.fix_n        <= def_fix_n;
      cfg.var_n        <= def_var_n;
      cfg.int_n        <= def_int_n;
      cfg.slow_rundown <= def_slow;
      cfg.himux_sel    <= def_himux;
    end
    else if (wr_en)
    begin
      case (addr)
        a_init_n: cfg.init_n <= wr_val;
        a_fix_n:  cfg.fix_n  <= wr_val;
        a_var_n:  cfg.var_n  <= wr_val;
        // integration period split over two addresses
        a_int_lo: cfg.int_n[cnt_w-1:0] <= wr_val;
        a_int_hi: cfg.int_n[int_w-1:cnt_w] <= wr_val[int_w-cnt_w-1:0];
        a_slow:   cfg.slow_rundown <= wr_val[0];
        a_himux:  cfg.himux_sel <= wr_val[3:0];
        default:  ;
      endcase
    end
  end

  ////////////////////
  // read select, sampled by the spi target after the address byte
  always_comb
  begin
    case (addr)
      a_count_up:   rd_word = result.count_up;
      a_count_down: rd_word = result.count_down;
      a_rundown:    rd_word = result.rundown;
      a_trans_up:   rd_word = result.trans_up;
      a_trans_down: rd_word = result.trans_down;
      a_fix_up:     rd_word = result.fix_up;
      a_fix_down:   rd_word = result.fix_down;
      a_test:       rd_word = test_word;
      a_init_n:     rd_word = cfg.init_n;
      a_fix_n:      rd_word = cfg.fix_n;
      a_var_n:      rd_word = cfg.var_n;
      a_int_lo:     rd_word = cfg.int_n[cnt_w-1:0];
      a_int_hi:     rd_word = cnt_w'(cfg.int_n[int_w-1:cnt_w]);
      a_slow:       rd_word = cnt_w'(cfg.slow_rundown);
      a_himux:      rd_word = cnt_w'(cfg.himux_sel);
      // unmapped addresses read zero
      default:      rd_word = '0;
    endcase
  end

endmodule

/* design/slope_counters.sv */
/*
  slope event counters
  - six working counters, cleared at the start of a conversion
  - result snapshot on the finish strobe, held until the next one
*/

`timescale 1ns/100ps

module slope_counters (
  input  logic                      clk,
  input  logic                      rst_n,
  input  adc_pkg::slope_ev_t        ev,
  input  logic [adc_pkg::cnt_w-1:0] rundown_count,
  output adc_pkg::mod_result_t      result
);

  import adc_pkg::*;

  localparam int n_cnt = 6;

  logic [cnt_w-1:0] cnt [n_cnt];
  logic [n_cnt-1:0] inc;

  // slot order
  // 0 up, 1 down, 2 trans up, 3 trans down, 4 fix up, 5 fix down
  // fixed positive reference drives the integrator down
  assign inc = {ev.fix_pos, ev.fix_neg, ev.trans_down, ev.trans_up,
                ev.var_down, ev.var_up};

  ////////////////////
  // working counters
  for (genvar i = 0; i < n_cnt; i++)
  begin : g_cnt
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
        cnt[i] <= '0;
      else if (ev.clear)
        cnt[i] <= '0;
      else if (inc[i])
        cnt[i] <= cnt[i] + 1'b1;
    end
  end

  ////////////////////
  // snapshot for the register bank
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      result <= '0;
    else if (ev.finish)
    begin
      result.count_up   <= cnt[0];
      result.count_down <= cnt[1];
      result.trans_up   <= cnt[2];
      result.trans_down <= cnt[3];
      result.fix_up     <= cnt[4];
      result.fix_down   <= cnt[5];
      // rundown clocks come straight from the sequencer
      result.rundown    <= rundown_count;
    end
  end

endmodule

/* design/modulation_seq.sv */
/*
  multislope modulation sequencer
  - init, four-phase run-up loop, rundown, done
  - phase timer, integration timer, rundown clock count
  - comparator synchroniser and zero-cross edge detect
  - event strobes for the slope counters
*/

`timescale 1ns/100ps

module modulation_seq (
  input  logic                      clk,
  input  logic                      rst_n,
  input  adc_pkg::mod_cfg_t         cfg,
  input  logic                      comparator,
  output adc_pkg::slope_ev_t        ev,
  output logic [adc_pkg::cnt_w-1:0] rundown_count,
  output adc_pkg::ref_code_t        ref_sel,
  output logic                      sig_en,
  output logic [3:0]                himux,
  output logic                      int_n
);

  import adc_pkg::*;

  seq_state_t       state;
  seq_state_t       next_state;
  mod_cfg_t         cfg_q;
  mod_cfg_t         run_cfg;
  logic             take_cfg;
  logic [cnt_w-1:0] phase_cnt;
  logic [cnt_w-1:0] phase_cnt_rd;
  logic [cnt_w-1:0] phase_len;
  logic             phase_last;
  logic             first;
  logic             runup;
  logic [int_w-1:0] int_cnt;
  logic             int_done;
  logic [2:0]       cmp_q;
  logic             cmp_s;
  logic             cmp_edge;
  ref_code_t        var_ref;
  ref_code_t        prev_ref;

  ////////////////////
  // comparator, two sync flops plus one for edges
  assign cmp_s    = cmp_q[1];
  assign cmp_edge = cmp_q[1] ^ cmp_q[2];

  // settings frozen for one conversion, copied in the first init cycle
  assign run_cfg = take_cfg ? cfg : cfg_q;
  assign himux   = run_cfg.himux_sel;

  always_ff @(posedge clk)
  begin
    if (take_cfg)
      cfg_q <= cfg;
  end

  ////////////////////
  // phase timing
  always_comb
  begin
    case (state)
      st_init:                phase_len = run_cfg.init_n;
      st_fix_pos, st_fix_neg: phase_len = run_cfg.fix_n;
      default:                phase_len = run_cfg.var_n;
    endcase
  end

  assign phase_last = (phase_cnt == phase_len - 1'b1);
  assign first      = (phase_cnt == '0);
  assign runup      = (state == st_fix_pos) || (state == st_var) ||
                      (state == st_fix_neg) || (state == st_var2);
  assign int_done   = (int_cnt == run_cfg.int_n);

  always_comb
  begin
    next_state = state;
    case (state)
      st_init:    if (phase_last) next_state = st_fix_pos;
      st_fix_pos: if (phase_last) next_state = st_var;
      st_var:     if (phase_last) next_state = st_fix_neg;
      st_fix_neg: if (phase_last) next_state = st_var2;
      st_var2:
        // leave only with integration over and the integrator above zero cross
        if (phase_last)
          next_state = (int_done && !cmp_s) ? st_rundown : st_fix_pos;
      st_rundown: if (cmp_edge) next_state = st_done;
      default:    next_state = st_init;
    endcase
  end

  ////////////////////
  // reference switches
  always_comb
  begin
    case (state)
      st_fix_pos:     ref_sel = ref_pos;
      st_fix_neg:     ref_sel = ref_neg;
      // direction picked on the first cycle, then held
      st_var, st_var2:
        ref_sel = first ? (cmp_s ? ref_neg : ref_pos) : var_ref;
      st_rundown:     ref_sel = run_cfg.slow_rundown ? ref_slow_pos : ref_pos;
      default:        ref_sel = ref_none;
    endcase
  end

  always_comb
  begin
    ev            = '0;
    ev.clear      = take_cfg;
    ev.finish     = (state == st_done);
    ev.fix_pos    = (state == st_fix_pos) && first;
    ev.fix_neg    = (state == st_fix_neg) && first;
    ev.var_up     = ((state == st_var) || (state == st_var2)) && first && cmp_s;
    ev.var_down   = ((state == st_var) || (state == st_var2)) && first && !cmp_s;
    // any change of reference, the first ref_pos after ref_none too
    ev.trans_up   = runup && (ref_sel == ref_neg) && (prev_ref != ref_neg);
    ev.trans_down = runup && (ref_sel == ref_pos) && (prev_ref != ref_pos);
  end

  assign int_n         = (state != st_done);
  assign rundown_count = phase_cnt_rd;

  ////////////////////
  // state and timers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= st_init;
      phase_cnt    <= '0;
      take_cfg     <= 1'b1;
      var_ref      <= ref_none;
      prev_ref     <= ref_none;
      cmp_q        <= '0;
      phase_cnt_rd <= '0;
      int_cnt      <= '0;
      sig_en       <= 1'b0;
    end
    else
    begin
      cmp_q     <= {cmp_q[1:0], comparator};
      state     <= next_state;
      phase_cnt <= (next_state != state) ? '0 : phase_cnt + 1'b1;
      take_cfg  <= (state == st_done);
      prev_ref  <= ref_sel;
      if (runup && first)
        var_ref <= ref_sel;
      // cycles spent with the rundown code out
      if (state == st_rundown)
        phase_cnt_rd <= phase_cnt_rd + 1'b1;
      else if (state == st_init)
        phase_cnt_rd <= '0;
      // integration window opens with the first fixed positive phase
      if (state == st_init)
      begin
        int_cnt <= phase_last ? int_w'(1) : '0;
        sig_en  <= phase_last;
      end
      else if (sig_en)
      begin
        if (int_done)
          sig_en <= 1'b0;
        else
          int_cnt <= int_cnt + 1'b1;
      end
    end
  end

  a_int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(int_n) |=> int_n);

  a_no_sig_rundown: assert property (@(posedge clk) disable iff (!rst_n)
    (state == st_rundown) |-> !sig_en);

endmodule

/* design/adc_top.sv */
/*
  adc controller top level
  - spi target and register bank
  - modulation sequencer and slope counters
  - reference select split onto the switch pins
*/

`timescale 1ns/100ps

module adc_top #(
  parameter logic [adc_pkg::cnt_w-1:0] def_init_n = 24'd10000,
  parameter logic [adc_pkg::cnt_w-1:0] def_fix_n  = 24'd700,
  parameter logic [adc_pkg::cnt_w-1:0] def_var_n  = 24'd5500,
  parameter logic [adc_pkg::int_w-1:0] def_int_n  = 32'd4000000,
  parameter logic                      def_slow   = 1'b1,
  parameter logic [3:0]                def_himux  = 4'b1011
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic       comparator,
  output logic       miso,
  output logic       int_n,
  output logic       ref_p,
  output logic       ref_n,
  output logic       sig,
  output logic [3:0] himux
);

  import adc_pkg::*;

  logic               frame_stb;
  logic [frame_w-1:0] frame;
  logic [cnt_w-1:0]   rd_word;
  mod_cfg_t           cfg;
  mod_result_t        result;
  slope_ev_t          ev;
  logic [cnt_w-1:0]   rundown_count;
  ref_code_t          ref_sel;

  assign {ref_n, ref_p} = ref_sel;

  spi_target #(.frame_w(frame_w)) i_spi (
    .clk, .rst_n, .sck, .cs_n, .mosi, .rd_word, .miso, .frame_stb, .frame
  );

  reg_bank #(
    .def_init_n(def_init_n), .def_fix_n(def_fix_n), .def_var_n(def_var_n),
    .def_int_n(def_int_n), .def_slow(def_slow), .def_himux(def_himux)
  ) i_regs (
    .clk, .rst_n, .frame_stb, .frame, .result, .cfg, .rd_word
  );

  modulation_seq i_seq (
    .clk, .rst_n, .cfg, .comparator, .ev, .rundown_count, .ref_sel,
    .sig_en(sig), .himux, .int_n
  );

  slope_counters i_cnt (
    .clk, .rst_n, .ev, .rundown_count, .result
  );

endmodule

/* dv/tb_adc.sv */
/*
  testbench for the multislope adc controller
  - clock, reset, spi frame tasks
  - register defaults, writes and read-only frames
  - table of conversions with predicted counts
  - cycle watchdog
*/

`timescale 1ns/100ps

module tb_adc;

  import adc_pkg::*;

  // one conversion setup
  typedef struct packed {
    int init_len;
    int fix_len;
    int var_len;
    int int_len;
    int slow;
    int mode;
    int k;
  } row_t;

  localparam int n_rows      = 5;
  localparam int frame_clks  = 272;
  localparam int fixed_frames = 24;
  localparam logic [3:0] himux_set = 4'h5;

  logic       clk;
  logic       rst_n;
  logic       sck;
  logic       cs_n;
  logic       mosi;
  logic       comparator;
  logic       miso;
  logic       int_n;
  logic       ref_p;
  logic       ref_n;
  logic       sig;
  logic [3:0] himux;

  row_t        rows [n_rows];
  int          cycle_cnt;
  int          cycle_limit;
  int          tests;
  int          checks;
  int          errors;
  int          test_errs;
  logic [23:0] rx;

  adc_top #(
    .def_init_n(24'd20), .def_fix_n(24'd6), .def_var_n(24'd10),
    .def_int_n(32'd300), .def_slow(1'b1), .def_himux(4'b1011)
  ) i_dut (
    .clk, .rst_n, .sck, .cs_n, .mosi, .comparator,
    .miso, .int_n, .ref_p, .ref_n, .sig, .himux
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("timeout: run went past %0d clock cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      test_errs++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errs++;
    $display("ERROR: %s", msg);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s: %s", name, (test_errs == 0) ? "ok" : "failed");
    test_errs = 0;
  endtask

  ////////////////////
  // spi host, half period of 4 clocks
  task automatic spi_frame(input logic [31:0] tx, output logic [23:0] data);
    data = '0;
    cs_n = 1'b0;
    repeat (4) @(negedge clk);
    for (int b = 0; b < 32; b++)
    begin
      mosi = tx[31-b];
      repeat (4) @(negedge clk);
      // miso settled since the last falling sck
      if (b >= 8)
        data = {data[22:0], miso};
      sck = 1'b1;
      repeat (4) @(negedge clk);
      sck = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    // strobe and write land within a few clocks
    repeat (8) @(negedge clk);
  endtask

  task automatic read_reg(input reg_addr_t addr, output logic [23:0] data);
    spi_frame({1'b1, addr, 24'h0}, data);
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [23:0] val);
    logic [23:0] unused;
    spi_frame({1'b0, addr, val}, unused);
  endtask

  task automatic expect_reg(input string name, input reg_addr_t addr,
                            input logic [23:0] expected);
    logic [23:0] data;
    read_reg(addr, data);
    check_value(name, expected, data);
  endtask

  ////////////////////
  // prediction from the phase rules
  function automatic int period(input row_t r);
    return 2 * r.fix_len + 2 * r.var_len;
  endfunction

  function automatic int loop_count(input row_t r);
    return (r.int_len + period(r) - 1) / period(r);
  endfunction

  function automatic mod_result_t expected_result(input row_t r);
    mod_result_t e;
    int p;
    int start;
    int prev;
    int cur;
    e = '0;
    p = period(r);
    prev = 0;
    for (int j = 0; j < loop_count(r); j++)
    begin
      for (int ph = 0; ph < 4; ph++)
      begin
        // 1 is ref_pos, 2 is ref_neg
        start = j * p + ((ph == 1) ? r.fix_len : 2 * r.fix_len + r.var_len);
        if (ph == 0)
          cur = 1;
        else if (ph == 2)
          cur = 2;
        else
          cur = (r.mode != 0 && start < r.int_len) ? 2 : 1;
        if (ph == 1 || ph == 3)
        begin
          if (cur == 2)
            e.count_up++;
          else
            e.count_down++;
        end
        if (cur != prev)
        begin
          if (cur == 2)
            e.trans_up++;
          else
            e.trans_down++;
        end
        prev = cur;
      end
    end
    e.fix_up  = loop_count(r);
    e.fix_down = loop_count(r);
    e.rundown = r.k + 3;
    return e;
  endfunction

  function automatic int budget();
    int total;
    total = fixed_frames * frame_clks;
    for (int i = 0; i < n_rows; i++)
      total += 14 * frame_clks + 2 * (rows[i].init_len +
               loop_count(rows[i]) * period(rows[i]) + rows[i].k + 8);
    return 2 * total;
  endfunction

  ////////////////////
  // one measured conversion, previous one waits in rundown
  task automatic run_conversion(input row_t r, input string name);
    int          lp;
    int          idx;
    int          code_cycles;
    logic        fell;
    logic [1:0]  code;
    mod_result_t e;
    lp = loop_count(r) * period(r);
    code = (r.slow != 0) ? 2'b11 : 2'b01;
    idx = 0;
    code_cycles = 0;
    fell = 1'b0;
    e = expected_result(r);
    // zero cross ends the parked rundown
    comparator = 1'b1;
    while (int_n)
      @(negedge clk);
    comparator = r.mode[0];
    while (!sig)
      @(negedge clk);
    // high mux follows the setting taken at this init
    check_value({name, " himux"}, himux_set, himux);
    while (int_n)
    begin
      if (!sig && !fell)
      begin
        fell = 1'b1;
        check_value({name, " sig fall"}, r.int_len, idx);
        if (r.mode != 0)
          comparator = 1'b0;
      end
      if (idx == lp && {ref_n, ref_p} != code)
        report_error({name, ": rundown code not on the pins at the predicted cycle"});
      if (idx >= lp && {ref_n, ref_p} == code)
        code_cycles++;
      if (idx == lp + r.k)
        comparator = 1'b1;
      @(negedge clk);
      idx++;
    end
    check_value({name, " done cycle"}, lp + r.k + 3, idx);
    check_value({name, " refs at int_n"}, 0, {ref_n, ref_p});
    @(negedge clk);
    check_value({name, " int_n width"}, 1, int_n);
    // next conversion parks in rundown
    comparator = 1'b0;
    expect_reg({name, " count_up"}, a_count_up, e.count_up);
    expect_reg({name, " count_down"}, a_count_down, e.count_down);
    expect_reg({name, " trans_up"}, a_trans_up, e.trans_up);
    expect_reg({name, " trans_down"}, a_trans_down, e.trans_down);
    expect_reg({name, " fix_up"}, a_fix_up, e.fix_up);
    expect_reg({name, " fix_down"}, a_fix_down, e.fix_down);
    expect_reg({name, " rundown"}, a_rundown, e.rundown);
    expect_reg({name, " rundown vs pins"}, a_rundown, code_cycles);
  endtask

  initial
  begin
    // init, fix, var, int, slow, comparator mode, k
    rows[0] = '{20, 6, 10, 300, 1, 0, 5};
    rows[1] = '{20, 6, 10, 300, 1, 1, 5};
    rows[2] = '{20, 6, 10, 300, 1, 1, 5};
    rows[3] = '{12, 4, 7, 140, 0, 1, 9};
    rows[4] = '{8, 3, 5, 55, 0, 0, 2};
    cycle_cnt = 0;
    cycle_limit = budget();
    tests = 0;
    checks = 0;
    errors = 0;
    test_errs = 0;
    rst_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    comparator = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    expect_reg("default init_n", a_init_n, 24'd20);
    expect_reg("default fix_n", a_fix_n, 24'd6);
    expect_reg("default var_n", a_var_n, 24'd10);
    expect_reg("default int_lo", a_int_lo, 24'd300);
    expect_reg("default int_hi", a_int_hi, 24'd0);
    expect_reg("default slow", a_slow, 24'd1);
    expect_reg("default himux", a_himux, 24'hb);
    expect_reg("test word", a_test, 24'hffffff);
    // first conversion runs on the reset settings
    check_value("default himux pins", 4'hb, himux);
    end_test("defaults");

    write_reg(a_init_n, 24'h00a1b2);
    expect_reg("write init_n", a_init_n, 24'h00a1b2);
    write_reg(a_fix_n, 24'h000456);
    expect_reg("write fix_n", a_fix_n, 24'h000456);
    write_reg(a_var_n, 24'h012345);
    expect_reg("write var_n", a_var_n, 24'h012345);
    write_reg(a_int_lo, 24'h5a5a5a);
    expect_reg("write int_lo", a_int_lo, 24'h5a5a5a);
    write_reg(a_int_hi, 24'h0000a5);
    expect_reg("write int_hi", a_int_hi, 24'h0000a5);
    write_reg(a_slow, 24'h000000);
    expect_reg("write slow", a_slow, 24'h000000);
    write_reg(a_himux, {20'h0, himux_set});
    expect_reg("write himux", a_himux, {20'h0, himux_set});
    end_test("writes");

    // address bit 7 set, value must be ignored
    spi_frame({1'b1, a_fix_n, 24'h123456}, rx);
    expect_reg("read-only frame", a_fix_n, 24'h000456);
    end_test("read_only");

    for (int i = 0; i < n_rows; i++)
    begin
      write_reg(a_init_n, rows[i].init_len);
      write_reg(a_fix_n, rows[i].fix_len);
      write_reg(a_var_n, rows[i].var_len);
      write_reg(a_int_lo, rows[i].int_len & 24'hffffff);
      write_reg(a_int_hi, rows[i].int_len >> 24);
      write_reg(a_slow, rows[i].slow);
      run_conversion(rows[i], $sformatf("row%0d", i));
      end_test($sformatf("conversion_row%0d", i));
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* all.f */
design/adc_pkg.sv
design/spi_target.sv
design/reg_bank.sv
design/slope_counters.sv
design/modulation_seq.sv
design/adc_top.sv
dv/tb_adc.sv
